//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
TOP       ?= tb_top
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
PASS_MSG  := Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- bench/tb_checker.sv
// Bus and interrupt response checker
`timescale 1ns/1ps

module tb_checker #(
	parameter int CYCLE_LIMIT = 1000
) (
	input  logic clk48mhz_i,
	input  logic rst_p,
	input  soc_pkg::pi1_req_t bus_req_i,
	input  soc_pkg::pi1_rsp_t bus_rsp_i,
	input  logic [soc_pkg::INTSRC_COUNT-1:0] src_rqst_i,
	input  logic [soc_pkg::INTSRC_COUNT-1:0] src_rdy_i,
	input  logic cpu_irq_i,
	input  logic sys_rst_i,
	input  logic powered_off_i,
	input  logic [3:0] test_id_i,
	input  logic report_i,
	input  logic done_i,
	output int err_total_o,
	output logic timeout_o
);

	// Expected responses, bit 32 says whether the data is compared
	logic [32:0] exp_q[$];
	logic [32:0] exp_item;

	// Reference state of reset sequencing and interrupt channels
	int hold_m = soc_pkg::RST_HOLD_CYCLES;
	logic off_m = 1'b0;
	logic [1:0] sw_m = 2'b00;
	logic rst_m;
	logic [soc_pkg::INTSRC_COUNT-1:0] pend_m = '0;
	logic [soc_pkg::INTSRC_COUNT-1:0] rdy_m = '0;
	logic [soc_pkg::INTSRC_COUNT-1:0] ack_m;
	logic irq_m = 1'b0;

	logic req_vld;
	logic is_rd;
	logic is_wr;
	int slot;
	logic rst_seen = 1'b0;
	logic armed = 1'b0;
	int cycles = 0;
	int test_errs = 0;
	int err_total = 0;
	int tests_run = 0;
	int tests_failed = 0;

	assign err_total_o = err_total;
	assign timeout_o = (cycles >= CYCLE_LIMIT);

	function automatic string test_name(input logic [3:0] id);
		case (id)
			4'd1: return "reset release";
			4'd2: return "device table";
			4'd3: return "unmapped access";
			4'd4: return "interrupt drain";
			4'd5: return "warm reset";
			4'd6: return "power off";
			default: return "unknown";
		endcase
	endfunction

	function automatic int lowest_pending(input logic [soc_pkg::INTSRC_COUNT-1:0] pend);
		for (int i = 0; i < soc_pkg::INTSRC_COUNT; i++) begin
			if (pend[i]) begin
				return i;
			end
		end
		return -1;
	endfunction

	// Windows follow each other from address 0 in slot order
	function automatic int slot_of(input logic [soc_pkg::ADDR_BITS-1:0] addr);
		logic [31:0] byte_a;
		logic [31:0] base;
		byte_a = {addr, 2'b00};
		base = '0;
		for (int s = 0; s < soc_pkg::SLV_COUNT; s++) begin
			if (byte_a >= base && byte_a < base + soc_pkg::SLV_MAPSZ[s]) begin
				return s;
			end
			base = base + soc_pkg::SLV_MAPSZ[s];
		end
		return soc_pkg::SLV_INVALID;
	endfunction

	function automatic logic [31:0] expected_read(input logic [soc_pkg::ADDR_BITS-1:0] addr,
		input logic [soc_pkg::INTSRC_COUNT-1:0] pend);
		logic [31:0] word;
		int s;
		word = ({addr, 2'b00} - soc_pkg::SLV_MAPSZ[soc_pkg::SLV_INTCTRL]) >> 2;
		s = int'(word >> 1);
		case (slot_of(addr))
			soc_pkg::SLV_INTCTRL: begin
				if (pend == '0) begin
					return soc_pkg::INTC_NONE;
				end
				return 32'(lowest_pending(pend));
			end
			soc_pkg::SLV_DEVTBL: begin
				if (s > soc_pkg::SLV_INVALID) begin
					return '0;
				end
				if (word[0]) begin
					return {soc_pkg::SLV_ID[s], 15'd0, soc_pkg::SLV_USEINTR[s]};
				end
				return soc_pkg::SLV_MAPSZ[s];
			end
			default: return '0;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (got !== exp) begin
			$display("ERROR %0t %s expected %h got %h", $time, name, exp, got);
			test_errs++;
			err_total++;
		end
	endtask

	task automatic report_failure(input string msg);
		$display("ERROR %0t %s", $time, msg);
		test_errs++;
		err_total++;
	endtask

	always @(posedge clk48mhz_i) begin
		req_vld = (bus_req_i.op != soc_pkg::PI1_OP_NONE);
		is_rd = (bus_req_i.op == soc_pkg::PI1_OP_RD) || (bus_req_i.op == soc_pkg::PI1_OP_RDWR);
		is_wr = (bus_req_i.op == soc_pkg::PI1_OP_WR) || (bus_req_i.op == soc_pkg::PI1_OP_RDWR);
		slot = slot_of(bus_req_i.addr);
		rst_m = (hold_m != 0) || off_m;

		if (armed) begin
			check_value("sys_rst_o", 32'(rst_m), 32'(sys_rst_i));
			check_value("powered_off_o", 32'(off_m), 32'(powered_off_i));
			check_value("cpu_irq_o", 32'(irq_m), 32'(cpu_irq_i));
			check_value("src_rdy_o", 32'(rdy_m), 32'(src_rdy_i));
			if (bus_rsp_i.rdy) begin
				if (exp_q.size() == 0) begin
					report_failure("bus response arrived without a request");
				end else begin
					exp_item = exp_q.pop_front();
					if (exp_item[32]) begin
						check_value("bus_rsp_o.data", exp_item[31:0], bus_rsp_i.data);
					end
				end
			end else if (exp_q.size() != 0) begin
				void'(exp_q.pop_front());
				report_failure("bus request was not answered on the next cycle");
			end
		end

		// A read of the interrupt controller takes the lowest pending source
		ack_m = '0;
		if (req_vld && is_rd && slot == soc_pkg::SLV_INTCTRL && pend_m != '0) begin
			ack_m[lowest_pending(pend_m)] = 1'b1;
		end
		if (armed && req_vld && !rst_m) begin
			exp_q.push_back({is_rd, expected_read(bus_req_i.addr, pend_m)});
		end

		if (rst_m) begin
			pend_m = '0;
			rdy_m = '0;
			irq_m = 1'b0;
		end else begin
			irq_m = |pend_m;
			pend_m = (pend_m | (src_rqst_i & ~rdy_m)) & ~ack_m;
			rdy_m = ack_m;
		end

		// Reset sequence reacts to the command levels of the previous cycle
		if (rst_p || sw_m[1] || sw_m == 2'b01) begin
			hold_m = soc_pkg::RST_HOLD_CYCLES;
		end else if (hold_m != 0) begin
			hold_m--;
		end
		if (rst_p) begin
			off_m = 1'b0;
		end else if (sw_m == 2'b01) begin
			off_m = 1'b1;
		end
		if (rst_m) begin
			sw_m = 2'b00;
		end else if (req_vld && is_wr && {bus_req_i.addr, 2'b00} ==
			soc_pkg::SLV_MAPSZ[soc_pkg::SLV_INTCTRL] + 32'(soc_pkg::DEVTBL_RST_WORD * 4)) begin
			sw_m = bus_req_i.data[1:0];
		end

		if (report_i) begin
			tests_run++;
			if (test_errs != 0) begin
				tests_failed++;
			end
			$display("test %0d %s: %s with %0d errors", test_id_i, test_name(test_id_i),
				(test_errs == 0) ? "passed" : "failed", test_errs);
			test_errs = 0;
		end
		if (done_i) begin
			$display("%0d tests run, %0d failed, %0d errors in total",
				tests_run, tests_failed, err_total);
		end

		cycles++;
		// DUT state is known once two edges have seen rst_p
		if (rst_p && rst_seen) begin
			armed = 1'b1;
		end
		if (rst_p) begin
			rst_seen = 1'b1;
		end
	end

endmodule

//--- bench/tb_top.sv
// SoC control core testbench
`timescale 1ns/1ps

module tb_top;

	localparam int N_RAND = 24;
	localparam int N_IRQ_ROUNDS = 6;
	localparam int RESET_CYCLES = 16;
	// Three reset phases, table reads, random accesses and interrupt rounds, doubled
	localparam int CYCLE_LIMIT = 2 * (3 * (RESET_CYCLES + soc_pkg::RST_HOLD_CYCLES + 8) + 40 +
		3 * N_RAND + N_IRQ_ROUNDS * (soc_pkg::INTSRC_COUNT + 12) + 40);

	logic clk48mhz = 1'b0;
	logic rst_p;
	soc_pkg::pi1_req_t bus_req;
	soc_pkg::pi1_rsp_t bus_rsp;
	logic [soc_pkg::INTSRC_COUNT-1:0] src_rqst = '0;
	logic [soc_pkg::INTSRC_COUNT-1:0] src_raise;
	logic [soc_pkg::INTSRC_COUNT-1:0] src_rdy;
	logic cpu_irq;
	logic sys_rst;
	logic powered_off;
	logic [3:0] test_id;
	logic report;
	logic done;
	int err_total;
	logic timeout;
	int seed = 32'h77fd17d2;

	always #5 clk48mhz = ~clk48mhz;

	// Sources hold their request until they see rdy
	always @(posedge clk48mhz) begin
		src_rqst <= (src_rqst & ~src_rdy) | src_raise;
	end

	soc_top DUT (
		.clk48mhz_i    (clk48mhz),
		.rst_p         (rst_p),
		.bus_req_i     (bus_req),
		.bus_rsp_o     (bus_rsp),
		.src_rqst_i    (src_rqst),
		.src_rdy_o     (src_rdy),
		.cpu_irq_o     (cpu_irq),
		.sys_rst_o     (sys_rst),
		.powered_off_o (powered_off)
	);

	tb_checker #(.CYCLE_LIMIT(CYCLE_LIMIT)) u_checker (
		.clk48mhz_i    (clk48mhz),
		.rst_p         (rst_p),
		.bus_req_i     (bus_req),
		.bus_rsp_i     (bus_rsp),
		.src_rqst_i    (src_rqst),
		.src_rdy_i     (src_rdy),
		.cpu_irq_i     (cpu_irq),
		.sys_rst_i     (sys_rst),
		.powered_off_i (powered_off),
		.test_id_i     (test_id),
		.report_i      (report),
		.done_i        (done),
		.err_total_o   (err_total),
		.timeout_o     (timeout)
	);

	function automatic logic [soc_pkg::ADDR_BITS-1:0] devtbl_addr(input int word);
		return soc_pkg::ADDR_BITS'((soc_pkg::SLV_MAPSZ[soc_pkg::SLV_INTCTRL] >> 2) + 32'(word));
	endfunction

	task automatic bus_issue(input soc_pkg::pi1_op_t op,
		input logic [soc_pkg::ADDR_BITS-1:0] addr, input logic [31:0] data);
		@(posedge clk48mhz);
		bus_req <= '{op: op, addr: addr, data: data, sel: 4'hF};
	endtask

	task automatic bus_idle(input int cycles);
		@(posedge clk48mhz);
		bus_req <= '0;
		repeat (cycles) @(posedge clk48mhz);
	endtask

	task automatic wait_reset_release();
		@(posedge clk48mhz);
		while (sys_rst) @(posedge clk48mhz);
	endtask

	task automatic close_test(input logic [3:0] id);
		test_id <= id;
		report <= 1'b1;
		@(posedge clk48mhz);
		report <= 1'b0;
	endtask

	initial begin : stimulus
		logic [31:0] rnd;
		logic [soc_pkg::INTSRC_COUNT-1:0] subset;
		int n_set;
		rst_p = 1'b1;
		bus_req = '0;
		src_raise = '0;
		test_id = '0;
		report = 1'b0;
		done = 1'b0;

		repeat (RESET_CYCLES) @(posedge clk48mhz);
		rst_p <= 1'b0;
		wait_reset_release();
		close_test(4'd1);

		// Every slot descriptor plus a few words that read zero, back to back
		for (int w = 0; w < 2 * (soc_pkg::SLV_INVALID + 1) + 2; w++) begin
			bus_issue(soc_pkg::PI1_OP_RD, devtbl_addr(w), '0);
		end
		bus_issue(soc_pkg::PI1_OP_RD, devtbl_addr(soc_pkg::DEVTBL_RST_WORD), '0);
		bus_idle(2);
		close_test(4'd2);

		// Bit 11 of the word address lies past both windows
		for (int i = 0; i < N_RAND; i++) begin
			rnd = $random(seed);
			bus_issue(rnd[31] ? soc_pkg::PI1_OP_WR : soc_pkg::PI1_OP_RD,
				rnd[29:0] | 30'h800, $random(seed));
		end
		bus_issue(soc_pkg::PI1_OP_RD, devtbl_addr(0), '0);
		bus_issue(soc_pkg::PI1_OP_RD, devtbl_addr(1), '0);
		bus_idle(2);
		close_test(4'd3);

		for (int r = 0; r < N_IRQ_ROUNDS; r++) begin
			rnd = $random(seed);
			subset = rnd[3:0];
			if (subset == '0) begin
				subset = 4'b0001 << rnd[5:4];
			end
			@(posedge clk48mhz);
			src_raise <= subset;
			@(posedge clk48mhz);
			src_raise <= '0;
			while (!cpu_irq) @(posedge clk48mhz);
			// One read per source, then one that finds nothing
			n_set = $countones(subset);
			for (int k = 0; k <= n_set; k++) begin
				bus_issue(soc_pkg::PI1_OP_RD, '0, '0);
			end
			bus_idle(3);
		end
		close_test(4'd4);

		bus_issue(soc_pkg::PI1_OP_WR, devtbl_addr(soc_pkg::DEVTBL_RST_WORD), 32'h2);
		bus_idle(0);
		while (!sys_rst) @(posedge clk48mhz);
		wait_reset_release();
		bus_issue(soc_pkg::PI1_OP_RD, devtbl_addr(1), '0);
		bus_idle(2);
		close_test(4'd5);

		bus_issue(soc_pkg::PI1_OP_WR, devtbl_addr(soc_pkg::DEVTBL_RST_WORD), 32'h1);
		bus_idle(0);
		while (!powered_off) @(posedge clk48mhz);
		repeat (20) @(posedge clk48mhz);
		rst_p <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clk48mhz);
		rst_p <= 1'b0;
		wait_reset_release();
		bus_issue(soc_pkg::PI1_OP_RD, devtbl_addr(0), '0);
		bus_idle(2);
		close_test(4'd6);

		@(posedge clk48mhz);
		done <= 1'b1;
		@(posedge clk48mhz);
		done <= 1'b0;
		@(negedge clk48mhz);
		if (err_total == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	always @(negedge clk48mhz) begin
		if (timeout) begin
			$display("Run stopped after reaching the limit of %0d cycles", CYCLE_LIMIT);
			$display("Something failed");
			$finish;
		end
	end

endmodule

//--- build.f
verilog/soc_pkg.sv
verilog/reset_ctrl.sv
verilog/bus_decoder.sv
verilog/dev_table.sv
verilog/intc_regs.sv
verilog/irq_channel.sv
verilog/irq_arbiter.sv
verilog/soc_top.sv
bench/tb_checker.sv
bench/tb_top.sv

//--- verilog/bus_decoder.sv
// PerInt address decoder
`timescale 1ns/1ps

module bus_decoder (
	input  logic clk48mhz_i,
	input  logic rst_p,
	input  soc_pkg::pi1_req_t bus_req_i,
	output soc_pkg::slv_req_t [soc_pkg::SLV_COUNT-1:0] slv_req_o,
	input  soc_pkg::pi1_rsp_t [soc_pkg::SLV_COUNT-1:0] slv_rsp_i,
	output soc_pkg::pi1_rsp_t bus_rsp_o
);

	logic [soc_pkg::ARCH_BITS-1:0] byte_addr;
	logic [soc_pkg::ARCH_BITS-1:0] win_base;
	logic [soc_pkg::ARCH_BITS-1:0] win_ofs;
	logic [soc_pkg::SLV_IDX_BITS-1:0] hit_idx;
	logic [soc_pkg::SLV_INVALID:0] stb_vec;
	logic req_vld;
	logic [soc_pkg::SLV_IDX_BITS-1:0] sel_q;
	logic dflt_rdy_q;

	assign byte_addr = {bus_req_i.addr, {(soc_pkg::ARCH_BITS-soc_pkg::ADDR_BITS){1'b0}}};
	assign req_vld = (bus_req_i.op != soc_pkg::PI1_OP_NONE);

	// Windows are stacked from address 0 in slave order
	always_comb begin
		win_base = '0;
		win_ofs = '0;
		hit_idx = soc_pkg::SLV_IDX_BITS'(soc_pkg::SLV_INVALID);
		for (int s = 0; s < soc_pkg::SLV_COUNT; s++) begin
			if (byte_addr >= win_base && (byte_addr - win_base) < soc_pkg::SLV_MAPSZ[s]) begin
				hit_idx = s[soc_pkg::SLV_IDX_BITS-1:0];
				win_ofs = byte_addr - win_base;
			end
			win_base = win_base + soc_pkg::SLV_MAPSZ[s];
		end
	end

	always_comb begin
		for (int s = 0; s <= soc_pkg::SLV_INVALID; s++) begin
			stb_vec[s] = req_vld && (int'(hit_idx) == s);
		end
		for (int s = 0; s < soc_pkg::SLV_COUNT; s++) begin
			slv_req_o[s].stb = stb_vec[s];
			slv_req_o[s].op = bus_req_i.op;
			slv_req_o[s].ofs = win_ofs[soc_pkg::SLV_OFS_BITS+1:2];
			slv_req_o[s].data = bus_req_i.data;
			slv_req_o[s].sel = bus_req_i.sel;
		end
	end

	// Remember who owes the next response; the default slave answers itself
	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			sel_q <= soc_pkg::SLV_IDX_BITS'(soc_pkg::SLV_INVALID);
			dflt_rdy_q <= 1'b0;
		end else begin
			dflt_rdy_q <= stb_vec[soc_pkg::SLV_INVALID];
			if (req_vld) begin
				sel_q <= hit_idx;
			end
		end
	end

	// Default slave reads as zero
	always_comb begin
		bus_rsp_o = '0;
		bus_rsp_o.rdy = dflt_rdy_q;
		for (int s = 0; s < soc_pkg::SLV_COUNT; s++) begin
			if (int'(sel_q) == s) begin
				bus_rsp_o = slv_rsp_i[s];
			end
		end
	end

	a_one_strobe: assert property (@(posedge clk48mhz_i) disable iff (rst_p)
		$onehot0(stb_vec));

	for (genvar g = 0; g < soc_pkg::SLV_COUNT; g++) begin : g_rdy_chk
		a_rdy_after_stb: assert property (@(posedge clk48mhz_i) disable iff (rst_p)
			slv_rsp_i[g].rdy |-> $past(stb_vec[g]));
	end

endmodule

//--- verilog/dev_table.sv
// Device descriptor table
`timescale 1ns/1ps

module dev_table (
	input  logic clk48mhz_i,
	input  logic rst_p,
	input  soc_pkg::slv_req_t slv_req_i,
	output soc_pkg::pi1_rsp_t slv_rsp_o,
	output logic sw_rst0_o,
	output logic sw_rst1_o
);

	logic [soc_pkg::SLV_OFS_BITS-2:0] slot;
	logic is_wr;
	logic rst_wr;
	logic [soc_pkg::ARCH_BITS-1:0] rd_data;
	logic [soc_pkg::ARCH_BITS-1:0] rsp_data_q;
	logic rsp_rdy_q;
	logic rst0_q;
	logic rst1_q;

	// Two words per slot, size first, then id and interrupt use
	assign slot = slv_req_i.ofs[soc_pkg::SLV_OFS_BITS-1:1];

	always_comb begin
		rd_data = '0;
		for (int s = 0; s <= soc_pkg::SLV_INVALID; s++) begin
			if (int'(slot) == s) begin
				if (slv_req_i.ofs[0]) begin
					rd_data = {soc_pkg::SLV_ID[s], {(soc_pkg::ARCH_BITS-17){1'b0}},
						soc_pkg::SLV_USEINTR[s]};
				end else begin
					rd_data = soc_pkg::SLV_MAPSZ[s];
				end
			end
		end
	end

	assign is_wr = (slv_req_i.op == soc_pkg::PI1_OP_WR) ||
		(slv_req_i.op == soc_pkg::PI1_OP_RDWR);
	assign rst_wr = slv_req_i.stb && is_wr && (int'(slv_req_i.ofs) == soc_pkg::DEVTBL_RST_WORD);

	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			rsp_rdy_q <= 1'b0;
			rst0_q <= 1'b0;
			rst1_q <= 1'b0;
		end else begin
			rsp_rdy_q <= slv_req_i.stb;
			if (rst_wr) begin
				rst0_q <= slv_req_i.data[0];
				rst1_q <= slv_req_i.data[1];
			end
		end
	end

	always_ff @(posedge clk48mhz_i) begin
		if (slv_req_i.stb) begin
			rsp_data_q <= rd_data;
		end
	end

	assign slv_rsp_o = '{data: rsp_data_q, rdy: rsp_rdy_q};
	assign sw_rst0_o = rst0_q;
	assign sw_rst1_o = rst1_q;

endmodule

//--- verilog/intc_regs.sv
// Interrupt controller bus register
`timescale 1ns/1ps

module intc_regs (
	input  logic clk48mhz_i,
	input  logic rst_p,
	input  soc_pkg::slv_req_t slv_req_i,
	output soc_pkg::pi1_rsp_t slv_rsp_o,
	input  logic [soc_pkg::INTSRC_IDX_BITS-1:0] best_idx_i,
	input  logic best_vld_i,
	output logic [soc_pkg::INTSRC_COUNT-1:0] ack_o
);

	logic acc_rd;
	logic [soc_pkg::ARCH_BITS-1:0] rd_data;
	logic [soc_pkg::ARCH_BITS-1:0] rsp_data_q;
	logic rsp_rdy_q;

	assign acc_rd = slv_req_i.stb && ((slv_req_i.op == soc_pkg::PI1_OP_RD) ||
		(slv_req_i.op == soc_pkg::PI1_OP_RDWR));

	assign rd_data = best_vld_i ?
		{{(soc_pkg::ARCH_BITS-soc_pkg::INTSRC_IDX_BITS){1'b0}}, best_idx_i} :
		soc_pkg::INTC_NONE;

	// Reading the index also takes the interrupt off that source
	always_comb begin
		ack_o = '0;
		if (acc_rd && best_vld_i) begin
			ack_o[best_idx_i] = 1'b1;
		end
	end

	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			rsp_rdy_q <= 1'b0;
		end else begin
			rsp_rdy_q <= slv_req_i.stb;
		end
	end

	// writes get an empty answer
	always_ff @(posedge clk48mhz_i) begin
		if (slv_req_i.stb) begin
			rsp_data_q <= acc_rd ? rd_data : '0;
		end
	end

	assign slv_rsp_o = '{data: rsp_data_q, rdy: rsp_rdy_q};

endmodule

//--- verilog/irq_arbiter.sv
// Interrupt priority selection
`timescale 1ns/1ps

module irq_arbiter (
	input  logic clk48mhz_i,
	input  logic rst_p,
	input  logic [soc_pkg::INTSRC_COUNT-1:0] pending_i,
	output logic [soc_pkg::INTSRC_IDX_BITS-1:0] best_idx_o,
	output logic best_vld_o,
	output logic cpu_irq_o
);

	logic cpu_irq_q;

	// Lowest index wins, so scan downward and keep the last hit
	always_comb begin
		best_idx_o = '0;
		for (int i = soc_pkg::INTSRC_COUNT - 1; i >= 0; i--) begin
			if (pending_i[i]) begin
				best_idx_o = i[soc_pkg::INTSRC_IDX_BITS-1:0];
			end
		end
	end

	assign best_vld_o = |pending_i;

	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			cpu_irq_q <= 1'b0;
		end else begin
			cpu_irq_q <= |pending_i;
		end
	end

	assign cpu_irq_o = cpu_irq_q;

endmodule

//--- verilog/irq_channel.sv
// Interrupt source channel
`timescale 1ns/1ps

module irq_channel (
	input  logic clk48mhz_i,
	input  logic rst_p,
	input  logic rqst_i,
	input  logic ack_i,
	output logic pending_o,
	output logic rdy_o
);

	logic pending_q;
	logic rdy_q;

	// The source still holds its request the cycle after rdy, so ignore it then
	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			pending_q <= 1'b0;
			rdy_q <= 1'b0;
		end else begin
			rdy_q <= ack_i;
			if (ack_i) begin
				pending_q <= 1'b0;
			end else if (rqst_i && !pending_q && !rdy_q) begin
				pending_q <= 1'b1;
			end
		end
	end

	assign pending_o = pending_q;
	assign rdy_o = rdy_q;

	// Controller must never acknowledge an idle source
	a_ack_pending: assert property (@(posedge clk48mhz_i) disable iff (rst_p)
		ack_i |-> pending_q);

endmodule

//--- verilog/reset_ctrl.sv
// Reset sequencing
`timescale 1ns/1ps

module reset_ctrl (
	input  logic clk48mhz_i,
	input  logic rst_p,
	input  logic sw_rst0_i,
	input  logic sw_rst1_i,
	output logic sys_rst_o,
	output logic powered_off_o
);

	logic warm_rst;
	logic pwr_off;
	logic [soc_pkg::RST_CNT_BITS-1:0] hold_cnt;
	logic pwr_off_q;

	// rst1 alone is warm, both together would be cold which we treat as warm
	assign warm_rst = sw_rst1_i;
	assign pwr_off = sw_rst0_i && !sw_rst1_i;

	// Hold-off counter, reloaded by every reset cause
	always_ff @(posedge clk48mhz_i) begin
		if (rst_p || warm_rst || pwr_off) begin
			hold_cnt <= soc_pkg::RST_CNT_BITS'(soc_pkg::RST_HOLD_CYCLES);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	// Power-off stays latched until the external reset
	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			pwr_off_q <= 1'b0;
		end else if (pwr_off) begin
			pwr_off_q <= 1'b1;
		end
	end

	assign sys_rst_o = (hold_cnt != '0) || pwr_off_q;
	assign powered_off_o = pwr_off_q;

	// Once off, the system stays off and in reset until rst_p
	a_pwr_off_hold: assert property (@(posedge clk48mhz_i)
		powered_off_o && !rst_p |=> powered_off_o && sys_rst_o);

endmodule

//--- verilog/soc_pkg.sv
// SoC fabric shared definitions
package soc_pkg;

	localparam int ARCH_BITS = 32;
	localparam int ADDR_BITS = 30;
	localparam int SEL_BITS = 4;
	localparam int SLV_OFS_BITS = 10;

	// PerInt operation codes
	typedef enum logic [1:0] {
		PI1_OP_NONE = 2'b00,
		PI1_OP_RDWR = 2'b01,
		PI1_OP_WR   = 2'b10,
		PI1_OP_RD   = 2'b11
	} pi1_op_t;

	typedef struct packed {
		pi1_op_t op;
		logic [ADDR_BITS-1:0] addr;
		logic [ARCH_BITS-1:0] data;
		logic [SEL_BITS-1:0] sel;
	} pi1_req_t;

	typedef struct packed {
		logic [ARCH_BITS-1:0] data;
		logic rdy;
	} pi1_rsp_t;

	// Request as seen by a slave, offset is relative to its window
	typedef struct packed {
		logic stb;
		pi1_op_t op;
		logic [SLV_OFS_BITS-1:0] ofs;
		logic [ARCH_BITS-1:0] data;
		logic [SEL_BITS-1:0] sel;
	} slv_req_t;

	localparam int SLV_INTCTRL = 0;
	localparam int SLV_DEVTBL = 1;
	localparam int SLV_COUNT = 2;
	localparam int SLV_INVALID = 2;
	localparam int SLV_IDX_BITS = $clog2(SLV_INVALID + 1);

	// Per slot tables, the default slot sits last
	localparam logic [SLV_INVALID:0][ARCH_BITS-1:0] SLV_MAPSZ = {
		32'h0000_1000,
		32'h0000_1000,
		32'h0000_1000
	};
	localparam logic [SLV_INVALID:0][15:0] SLV_ID = {16'd0, 16'd7, 16'd3};
	localparam logic [SLV_INVALID:0] SLV_USEINTR = 3'b000;

	localparam int DEVTBL_RST_WORD = 63;

	localparam int INTSRC_COUNT = 4;
	localparam int INTSRC_IDX_BITS = 2;
	localparam logic [ARCH_BITS-1:0] INTC_NONE = 32'hFFFF_FFFF;

	localparam int RST_HOLD_CYCLES = 16;
	localparam int RST_CNT_BITS = $clog2(RST_HOLD_CYCLES + 1);

endpackage

//--- verilog/soc_top.sv
// SoC control core top level
`timescale 1ns/1ps

module soc_top (
	input  logic clk48mhz_i,
	input  logic rst_p,
	input  soc_pkg::pi1_req_t bus_req_i,
	output soc_pkg::pi1_rsp_t bus_rsp_o,
	input  logic [soc_pkg::INTSRC_COUNT-1:0] src_rqst_i,
	output logic [soc_pkg::INTSRC_COUNT-1:0] src_rdy_o,
	output logic cpu_irq_o,
	output logic sys_rst_o,
	output logic powered_off_o
);

	soc_pkg::slv_req_t [soc_pkg::SLV_COUNT-1:0] slv_req;
	soc_pkg::pi1_rsp_t [soc_pkg::SLV_COUNT-1:0] slv_rsp;

	logic sw_rst0;
	logic sw_rst1;

	logic [soc_pkg::INTSRC_COUNT-1:0] intc_ack;
	logic [soc_pkg::INTSRC_COUNT-1:0] irq_pending;
	logic [soc_pkg::INTSRC_IDX_BITS-1:0] best_idx;
	logic best_vld;

	reset_ctrl u_reset_ctrl (
		.clk48mhz_i    (clk48mhz_i),
		.rst_p         (rst_p),
		.sw_rst0_i     (sw_rst0),
		.sw_rst1_i     (sw_rst1),
		.sys_rst_o     (sys_rst_o),
		.powered_off_o (powered_off_o)
	);

	// Everything past the reset controller runs on the sequenced reset
	bus_decoder u_bus_decoder (
		.clk48mhz_i (clk48mhz_i),
		.rst_p      (sys_rst_o),
		.bus_req_i  (bus_req_i),
		.slv_req_o  (slv_req),
		.slv_rsp_i  (slv_rsp),
		.bus_rsp_o  (bus_rsp_o)
	);

	dev_table u_dev_table (
		.clk48mhz_i (clk48mhz_i),
		.rst_p      (sys_rst_o),
		.slv_req_i  (slv_req[soc_pkg::SLV_DEVTBL]),
		.slv_rsp_o  (slv_rsp[soc_pkg::SLV_DEVTBL]),
		.sw_rst0_o  (sw_rst0),
		.sw_rst1_o  (sw_rst1)
	);

	intc_regs u_intc_regs (
		.clk48mhz_i (clk48mhz_i),
		.rst_p      (sys_rst_o),
		.slv_req_i  (slv_req[soc_pkg::SLV_INTCTRL]),
		.slv_rsp_o  (slv_rsp[soc_pkg::SLV_INTCTRL]),
		.best_idx_i (best_idx),
		.best_vld_i (best_vld),
		.ack_o      (intc_ack)
	);

	for (genvar g = 0; g < soc_pkg::INTSRC_COUNT; g++) begin : g_irq_chan
		irq_channel u_irq_channel (
			.clk48mhz_i (clk48mhz_i),
			.rst_p      (sys_rst_o),
			.rqst_i     (src_rqst_i[g]),
			.ack_i      (intc_ack[g]),
			.pending_o  (irq_pending[g]),
			.rdy_o      (src_rdy_o[g])
		);
	end

	irq_arbiter u_irq_arbiter (
		.clk48mhz_i (clk48mhz_i),
		.rst_p      (sys_rst_o),
		.pending_i  (irq_pending),
		.best_idx_o (best_idx),
		.best_vld_o (best_vld),
		.cpu_irq_o  (cpu_irq_o)
	);

endmodule
